// ==== ntps_pkg.sv ====
// Shared constants for the NTP server interface core.
// Holds bus widths, the per-path register map and the idle XGMII pattern.

package ntps_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int NUM_PATHS     = 3;

  localparam int AXI_DATA_W    = 32;
  localparam int AXI_ADDR_W    = 9;
  localparam int AXI_STRB_W    = AXI_DATA_W / 8;
  localparam int AXI_RESP_W    = 2;

  localparam int NTP_TIME_W    = 64;
  localparam int XPHY_STATUS_W = 5;

  localparam int XGMII_DATA_W  = 64;
  localparam int XGMII_CTRL_W  = 8;

  // --------------------------------------------------
  // Network path register map
  // --------------------------------------------------
  localparam logic [AXI_ADDR_W-1:0] REG_GEN_CONFIG   = 9'h000;
  localparam logic [AXI_ADDR_W-1:0] REG_STATUS       = 9'h004;
  localparam logic [AXI_ADDR_W-1:0] REG_CORE_VERSION = 9'h008;

  // Version word, ASCII "np01"
  localparam logic [AXI_DATA_W-1:0] CORE_VERSION     = 32'h6e70_3031;

  // Sync flag position in the status word, PHY status sits in the low bits
  localparam int STATUS_SYNC_BIT = 8;

  // Config bit 24 of path 0 picks the time source
  localparam int CLOCK_SELECT_BIT = 24;

  // --------------------------------------------------
  // AXI responses
  // --------------------------------------------------
  localparam logic [AXI_RESP_W-1:0] RESP_OKAY   = 2'b00;
  localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;

  // --------------------------------------------------
  // XGMII idle
  // --------------------------------------------------
  localparam logic [XGMII_DATA_W-1:0] XGMII_IDLE_DATA = 64'h0707_0707_0707_0707;
  localparam logic [XGMII_CTRL_W-1:0] XGMII_IDLE_CTRL = 8'hff;

endpackage

// ==== network_path_regs.sv ====
// AXI-lite register slave for one network path.
// Holds the general config word and reports PHY status and the shared sync flag.

`timescale 1ns/1ns

module network_path_regs
  import ntps_pkg::*;
(
  input  logic                     clk156,
  input  logic                     arst_n,

  // Write address and data
  input  logic [AXI_ADDR_W-1:0]    awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [AXI_DATA_W-1:0]    wdata,
  input  logic [AXI_STRB_W-1:0]    wstrb,
  input  logic                     wvalid,
  output logic                     wready,

  // Write response
  output logic [AXI_RESP_W-1:0]    bresp,
  output logic                     bvalid,
  input  logic                     bready,

  // Read address and data
  input  logic [AXI_ADDR_W-1:0]    araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [AXI_DATA_W-1:0]    rdata,
  output logic [AXI_RESP_W-1:0]    rresp,
  output logic                     rvalid,
  input  logic                     rready,

  // Path status and config
  input  logic [XPHY_STATUS_W-1:0] xphy_status,
  input  logic                     ntp_sync_ok,
  output logic [AXI_DATA_W-1:0]    gen_config
);

  logic                  wr_hit_config;
  logic [AXI_DATA_W-1:0] status_word;
  logic [AXI_DATA_W-1:0] rd_mux_data;
  logic [AXI_RESP_W-1:0] rd_mux_resp;

  // --------------------------------------------------
  // Write channel
  // --------------------------------------------------
  assign wr_hit_config = (awaddr == REG_GEN_CONFIG);

  // Address and data ready each pulse for one cycle, both on the same edge
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= 1'b0;
      if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
      end

      wready <= 1'b0;
      if (awvalid && wvalid && !wready && !bvalid) begin
        wready <= 1'b1;
      end

      // Transfer completes on the edge that ends the ready pulse
      if (awready) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk156) begin
    if (awready) begin
      bresp <= wr_hit_config ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // Config word, byte enables from wstrb
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      gen_config <= '0;
    end else if (awready && wr_hit_config) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (wstrb[i]) begin
          gen_config[8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // Read channel
  // --------------------------------------------------
  always_comb begin
    status_word                       = '0;
    status_word[STATUS_SYNC_BIT]      = ntp_sync_ok;
    status_word[XPHY_STATUS_W-1:0]    = xphy_status;
  end

  always_comb begin
    rd_mux_resp = RESP_OKAY;
    case (araddr)
      REG_GEN_CONFIG:   rd_mux_data = gen_config;
      REG_STATUS:       rd_mux_data = status_word;
      REG_CORE_VERSION: rd_mux_data = CORE_VERSION;
      default: begin
        rd_mux_data = '0;
        rd_mux_resp = RESP_SLVERR;
      end
    endcase
  end

  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (arvalid && !arready && !rvalid) begin
        arready <= 1'b1;
      end

      if (arready) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read data captured while the address is still held
  always_ff @(posedge clk156) begin
    if (arready) begin
      rdata <= rd_mux_data;
      rresp <= rd_mux_resp;
    end
  end

endmodule

// ==== ntp_clock_select.sv ====
// Common NTP clock select.
// Registers time and sync flag from source A or B, picked by the select input.

`timescale 1ns/1ns

module ntp_clock_select
  import ntps_pkg::*;
(
  input  logic                  clk156,
  input  logic                  arst_n,

  // High picks source B
  input  logic                  select,

  input  logic [NTP_TIME_W-1:0] ntp_time_a,
  input  logic                  ntp_time_upd_a,
  input  logic                  ntp_sync_ok_a,

  input  logic [NTP_TIME_W-1:0] ntp_time_b,
  input  logic                  ntp_time_upd_b,
  input  logic                  ntp_sync_ok_b,

  output logic [NTP_TIME_W-1:0] ntp_time,
  output logic                  ntp_sync_ok
);

  logic [NTP_TIME_W-1:0] sel_time;
  logic                  sel_upd;
  logic                  sel_sync_ok;

  // --------------------------------------------------
  // Source mux
  // --------------------------------------------------
  always_comb begin
    if (select) begin
      sel_time    = ntp_time_b;
      sel_upd     = ntp_time_upd_b;
      sel_sync_ok = ntp_sync_ok_b;
    end else begin
      sel_time    = ntp_time_a;
      sel_upd     = ntp_time_upd_a;
      sel_sync_ok = ntp_sync_ok_a;
    end
  end

  // Time only loads on the chosen strobe, so it never mixes sources
  always_ff @(posedge clk156 or negedge arst_n) begin
    if (!arst_n) begin
      ntp_time    <= '0;
      ntp_sync_ok <= 1'b0;
    end else begin
      if (sel_upd) begin
        ntp_time <= sel_time;
      end
      ntp_sync_ok <= sel_sync_ok;
    end
  end

endmodule

// ==== ntps_interfaces.sv ====
// Top of the NTP server interface core.
// One AXI-lite register slave per network path, the shared clock select
// and idle XGMII transmit lanes.

`timescale 1ns/1ns

module ntps_interfaces
  import ntps_pkg::*;
(
  input  logic                              clk156,
  input  logic                              arst_n,

  // Per-path AXI-lite, slot p belongs to path p
  input  logic [NUM_PATHS*AXI_ADDR_W-1:0]    awaddr,
  input  logic [NUM_PATHS-1:0]               awvalid,
  output logic [NUM_PATHS-1:0]               awready,
  input  logic [NUM_PATHS*AXI_DATA_W-1:0]    wdata,
  input  logic [NUM_PATHS*AXI_STRB_W-1:0]    wstrb,
  input  logic [NUM_PATHS-1:0]               wvalid,
  output logic [NUM_PATHS-1:0]               wready,
  output logic [NUM_PATHS*AXI_RESP_W-1:0]    bresp,
  output logic [NUM_PATHS-1:0]               bvalid,
  input  logic [NUM_PATHS-1:0]               bready,
  input  logic [NUM_PATHS*AXI_ADDR_W-1:0]    araddr,
  input  logic [NUM_PATHS-1:0]               arvalid,
  output logic [NUM_PATHS-1:0]               arready,
  output logic [NUM_PATHS*AXI_DATA_W-1:0]    rdata,
  output logic [NUM_PATHS*AXI_RESP_W-1:0]    rresp,
  output logic [NUM_PATHS-1:0]               rvalid,
  input  logic [NUM_PATHS-1:0]               rready,

  // Path status and config
  input  logic [NUM_PATHS*XPHY_STATUS_W-1:0] xphy_status,
  output logic [NUM_PATHS*AXI_DATA_W-1:0]    gen_config,

  // Time sources
  input  logic [NTP_TIME_W-1:0]              ntp_time_a,
  input  logic                               ntp_time_upd_a,
  input  logic                               ntp_sync_ok_a,
  input  logic [NTP_TIME_W-1:0]              ntp_time_b,
  input  logic                               ntp_time_upd_b,
  input  logic                               ntp_sync_ok_b,

  // Selected time
  output logic [NTP_TIME_W-1:0]              ntp_time,
  output logic                               ntp_sync_ok,

  // 10G transmit lanes
  output logic [NUM_PATHS*XGMII_DATA_W-1:0]  xgmii_txd,
  output logic [NUM_PATHS*XGMII_CTRL_W-1:0]  xgmii_txc
);

  // --------------------------------------------------
  // Clock select, driven by path 0 config
  // --------------------------------------------------
  ntp_clock_select ntp_clock_select_i (
    .clk156         (clk156),
    .arst_n         (arst_n),
    .select         (gen_config[CLOCK_SELECT_BIT]),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .ntp_time       (ntp_time),
    .ntp_sync_ok    (ntp_sync_ok)
  );

  // --------------------------------------------------
  // Network paths
  // --------------------------------------------------
  for (genvar p = 0; p < NUM_PATHS; p++) begin : gen_path
    network_path_regs network_path_regs_i (
      .clk156      (clk156),
      .arst_n      (arst_n),
      .awaddr      (awaddr     [p*AXI_ADDR_W    +: AXI_ADDR_W]),
      .awvalid     (awvalid    [p]),
      .awready     (awready    [p]),
      .wdata       (wdata      [p*AXI_DATA_W    +: AXI_DATA_W]),
      .wstrb       (wstrb      [p*AXI_STRB_W    +: AXI_STRB_W]),
      .wvalid      (wvalid     [p]),
      .wready      (wready     [p]),
      .bresp       (bresp      [p*AXI_RESP_W    +: AXI_RESP_W]),
      .bvalid      (bvalid     [p]),
      .bready      (bready     [p]),
      .araddr      (araddr     [p*AXI_ADDR_W    +: AXI_ADDR_W]),
      .arvalid     (arvalid    [p]),
      .arready     (arready    [p]),
      .rdata       (rdata      [p*AXI_DATA_W    +: AXI_DATA_W]),
      .rresp       (rresp      [p*AXI_RESP_W    +: AXI_RESP_W]),
      .rvalid      (rvalid     [p]),
      .rready      (rready     [p]),
      .xphy_status (xphy_status[p*XPHY_STATUS_W +: XPHY_STATUS_W]),
      .ntp_sync_ok (ntp_sync_ok),
      .gen_config  (gen_config [p*AXI_DATA_W    +: AXI_DATA_W])
    );

    // No engines here, lanes send idle
    assign xgmii_txd[p*XGMII_DATA_W +: XGMII_DATA_W] = XGMII_IDLE_DATA;
    assign xgmii_txc[p*XGMII_CTRL_W +: XGMII_CTRL_W] = XGMII_IDLE_CTRL;
  end

endmodule

// ==== ntps_asserts.sv ====
// Concurrent checks for the NTP interface top, bound into every ntps_interfaces.
// Covers the AXI-lite response hold rules and the clock select timing.

`timescale 1ns/1ns

module ntps_asserts
  import ntps_pkg::*;
(
  input logic                          clk156,
  input logic                          arst_n,
  input logic [NUM_PATHS-1:0]          awready,
  input logic [NUM_PATHS-1:0]          wready,
  input logic [NUM_PATHS-1:0]          bvalid,
  input logic [NUM_PATHS-1:0]          bready,
  input logic [NUM_PATHS*AXI_RESP_W-1:0] bresp,
  input logic [NUM_PATHS-1:0]          rvalid,
  input logic [NUM_PATHS-1:0]          rready,
  input logic [NUM_PATHS*AXI_RESP_W-1:0] rresp,
  input logic [NUM_PATHS*AXI_DATA_W-1:0] rdata,
  input logic [NUM_PATHS*AXI_DATA_W-1:0] gen_config,
  input logic [NTP_TIME_W-1:0]         ntp_time_a,
  input logic                          ntp_time_upd_a,
  input logic                          ntp_sync_ok_a,
  input logic [NTP_TIME_W-1:0]         ntp_time_b,
  input logic                          ntp_time_upd_b,
  input logic                          ntp_sync_ok_b,
  input logic [NTP_TIME_W-1:0]         ntp_time,
  input logic                          ntp_sync_ok
);

  int unsigned fail_count = 0;

  logic                  src_b;
  logic                  src_upd;
  logic [NTP_TIME_W-1:0] src_time;
  logic                  src_sync;

  // Source picked by path 0 config
  assign src_b    = gen_config[CLOCK_SELECT_BIT];
  assign src_upd  = src_b ? ntp_time_upd_b : ntp_time_upd_a;
  assign src_time = src_b ? ntp_time_b : ntp_time_a;
  assign src_sync = src_b ? ntp_sync_ok_b : ntp_sync_ok_a;

  // --------------------------------------------------
  // AXI-lite channel rules
  // --------------------------------------------------
  ready_pair: assert property (@(posedge clk156) disable iff (!arst_n) awready == wready)
    else begin
      $error("awready and wready differ");
      fail_count++;
    end

  for (genvar p = 0; p < NUM_PATHS; p++) begin : gen_path_checks
    b_hold: assert property (@(posedge clk156) disable iff (!arst_n)
      bvalid[p] && !bready[p] |=> bvalid[p] && $stable(bresp[p*AXI_RESP_W +: AXI_RESP_W]))
      else begin
        $error("bvalid or bresp changed before bready");
        fail_count++;
      end

    r_hold: assert property (@(posedge clk156) disable iff (!arst_n)
      rvalid[p] && !rready[p] |=> rvalid[p] && $stable(rresp[p*AXI_RESP_W +: AXI_RESP_W])
        && $stable(rdata[p*AXI_DATA_W +: AXI_DATA_W]))
      else begin
        $error("rvalid, rresp or rdata changed before rready");
        fail_count++;
      end
  end

  // --------------------------------------------------
  // Clock select
  // --------------------------------------------------
  time_load: assert property (@(posedge clk156) disable iff (!arst_n)
    src_upd |=> ntp_time == $past(src_time))
    else begin
      $error("ntp_time did not load the chosen time");
      fail_count++;
    end

  time_hold: assert property (@(posedge clk156) disable iff (!arst_n)
    !src_upd |=> $stable(ntp_time))
    else begin
      $error("ntp_time moved without a chosen update");
      fail_count++;
    end

  sync_follow: assert property (@(posedge clk156) disable iff (!arst_n)
    1'b1 |=> ntp_sync_ok == $past(src_sync))
    else begin
      $error("ntp_sync_ok does not follow the chosen flag");
      fail_count++;
    end

endmodule

bind ntps_interfaces ntps_asserts ntps_asserts_i (.*);

// ==== tb_clock_gen.sv ====
// Clock and reset generator for the NTP interface testbench.
// 10 ns clock, reset held low for the first 3 rising edges.

`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk156,
  output logic arst_n
);

  initial begin
    clk156 = 1'b0;
    forever #5 clk156 = ~clk156;
  end

  // Release just after the third edge, clear of the sampling point
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk156);
    #1 arst_n = 1'b1;
  end

endmodule

// ==== tb_ntps.sv ====
// Testbench top for the NTP server interface core.
// Runs AXI-lite register tests on every path and exercises the clock select.

`timescale 1ns/1ns

module tb_ntps
  import ntps_pkg::*;
();

  localparam int NUM_TESTS = 6;

  logic                              clk156;
  logic                              arst_n;
  logic [NUM_PATHS*AXI_ADDR_W-1:0]    awaddr;
  logic [NUM_PATHS-1:0]               awvalid;
  logic [NUM_PATHS-1:0]               awready;
  logic [NUM_PATHS*AXI_DATA_W-1:0]    wdata;
  logic [NUM_PATHS*AXI_STRB_W-1:0]    wstrb;
  logic [NUM_PATHS-1:0]               wvalid;
  logic [NUM_PATHS-1:0]               wready;
  logic [NUM_PATHS*AXI_RESP_W-1:0]    bresp;
  logic [NUM_PATHS-1:0]               bvalid;
  logic [NUM_PATHS-1:0]               bready;
  logic [NUM_PATHS*AXI_ADDR_W-1:0]    araddr;
  logic [NUM_PATHS-1:0]               arvalid;
  logic [NUM_PATHS-1:0]               arready;
  logic [NUM_PATHS*AXI_DATA_W-1:0]    rdata;
  logic [NUM_PATHS*AXI_RESP_W-1:0]    rresp;
  logic [NUM_PATHS-1:0]               rvalid;
  logic [NUM_PATHS-1:0]               rready;
  logic [NUM_PATHS*XPHY_STATUS_W-1:0] xphy_status;
  logic [NUM_PATHS*AXI_DATA_W-1:0]    gen_config;
  logic [NTP_TIME_W-1:0]              ntp_time_a;
  logic                               ntp_time_upd_a;
  logic                               ntp_sync_ok_a;
  logic [NTP_TIME_W-1:0]              ntp_time_b;
  logic                               ntp_time_upd_b;
  logic                               ntp_sync_ok_b;
  logic [NTP_TIME_W-1:0]              ntp_time;
  logic                               ntp_sync_ok;
  logic [NUM_PATHS*XGMII_DATA_W-1:0]  xgmii_txd;
  logic [NUM_PATHS*XGMII_CTRL_W-1:0]  xgmii_txc;

  int unsigned           errors;
  int unsigned           tests_failed;
  int unsigned           mark;
  logic [31:0]           rng_state;
  logic [AXI_DATA_W-1:0] cfg_model [NUM_PATHS];
  logic [NTP_TIME_W-1:0] time_exp;

  tb_clock_gen clock_gen_i (
    .clk156 (clk156),
    .arst_n (arst_n)
  );

  ntps_interfaces dut_i (.*);

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int unsigned total_errors();
    return errors + dut_i.ntps_asserts_i.fail_count;
  endfunction

  // Config word after a write, one byte per strobe bit
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < AXI_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  task automatic step_cycle();
    @(posedge clk156);
    #1;
  endtask

  task automatic check_equal(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_config();
    for (int p = 0; p < NUM_PATHS; p++) begin
      check_equal("gen_config port", gen_config[p*AXI_DATA_W +: AXI_DATA_W], cfg_model[p]);
    end
  endtask

  task automatic write_reg(input int p, input logic [AXI_ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input int stall, input logic [1:0] resp_exp);
    awaddr[p*AXI_ADDR_W +: AXI_ADDR_W] = addr;
    wdata[p*AXI_DATA_W +: AXI_DATA_W]  = data;
    wstrb[p*AXI_STRB_W +: AXI_STRB_W]  = strb;
    awvalid[p] = 1'b1;
    wvalid[p]  = 1'b1;
    do step_cycle(); while (!awready[p]);
    // Valid held through the edge that takes the transfer
    step_cycle();
    awvalid[p] = 1'b0;
    wvalid[p]  = 1'b0;
    repeat (stall) step_cycle();
    check_equal("bvalid", bvalid[p], 1'b1);
    check_equal("bresp", bresp[p*AXI_RESP_W +: AXI_RESP_W], resp_exp);
    bready[p] = 1'b1;
    step_cycle();
    bready[p] = 1'b0;
  endtask

  task automatic read_reg(input int p, input logic [AXI_ADDR_W-1:0] addr, input int stall,
                          input logic [31:0] data_exp, input logic [1:0] resp_exp);
    araddr[p*AXI_ADDR_W +: AXI_ADDR_W] = addr;
    arvalid[p] = 1'b1;
    do step_cycle(); while (!arready[p]);
    step_cycle();
    arvalid[p] = 1'b0;
    repeat (stall) step_cycle();
    check_equal("rvalid", rvalid[p], 1'b1);
    check_equal("rdata", rdata[p*AXI_DATA_W +: AXI_DATA_W], data_exp);
    check_equal("rresp", rresp[p*AXI_RESP_W +: AXI_RESP_W], resp_exp);
    rready[p] = 1'b1;
    step_cycle();
    rready[p] = 1'b0;
  endtask

  task automatic pulse_update(input logic src_b);
    ntp_time_upd_a = !src_b;
    ntp_time_upd_b = src_b;
    step_cycle();
    ntp_time_upd_a = 1'b0;
    ntp_time_upd_b = 1'b0;
  endtask

  task automatic report_test(input string name);
    if (total_errors() == mark) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: fail", name);
      tests_failed++;
    end
    mark = total_errors();
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------
  initial begin
    #(NUM_TESTS * 2000);
    $display("run timed out after %0d ns, a handshake never completed", NUM_TESTS * 2000);
    $display("TESTBENCH FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    logic [31:0]           rnd;
    logic [31:0]           wr_data;
    logic [AXI_DATA_W-1:0] status_exp;
    int                    p_sel;

    awaddr         = '0;
    awvalid        = '0;
    wdata          = '0;
    wstrb          = '0;
    wvalid         = '0;
    bready         = '0;
    araddr         = '0;
    arvalid        = '0;
    rready         = '0;
    xphy_status    = '0;
    ntp_time_a     = '0;
    ntp_time_upd_a = 1'b0;
    ntp_sync_ok_a  = 1'b0;
    ntp_time_b     = '0;
    ntp_time_upd_b = 1'b0;
    ntp_sync_ok_b  = 1'b0;
    rng_state      = 32'd70752;
    errors         = 0;
    tests_failed   = 0;
    time_exp       = '0;
    for (int p = 0; p < NUM_PATHS; p++) begin
      cfg_model[p] = '0;
    end
    wait (arst_n);
    step_cycle();
    mark = total_errors();

    // Idle lanes carry 0x07 in every byte with every control bit set
    for (int p = 0; p < NUM_PATHS; p++) begin
      read_reg(p, REG_GEN_CONFIG, 0, '0, RESP_OKAY);
      read_reg(p, REG_CORE_VERSION, 0, CORE_VERSION, RESP_OKAY);
      check_equal("xgmii_txd", xgmii_txd[p*XGMII_DATA_W +: XGMII_DATA_W],
                  {XGMII_DATA_W/8{8'h07}});
      check_equal("xgmii_txc", xgmii_txc[p*XGMII_CTRL_W +: XGMII_CTRL_W],
                  {XGMII_CTRL_W{1'b1}});
    end
    check_equal("ntp_sync_ok", ntp_sync_ok, 1'b0);
    check_config();
    report_test("reset values");

    for (int i = 0; i < 4 * NUM_PATHS; i++) begin
      p_sel   = next_random() % NUM_PATHS;
      wr_data = next_random();
      rnd     = next_random();
      write_reg(p_sel, REG_GEN_CONFIG, wr_data, rnd[3:0], 0, RESP_OKAY);
      cfg_model[p_sel] = merge_bytes(cfg_model[p_sel], wr_data, rnd[3:0]);
      read_reg(p_sel, REG_GEN_CONFIG, 0, cfg_model[p_sel], RESP_OKAY);
      check_config();
    end
    report_test("strobed config writes");

    for (int p = 0; p < NUM_PATHS; p++) begin
      write_reg(p, REG_STATUS, next_random(), 4'hf, 0, RESP_SLVERR);
      write_reg(p, 9'h010, next_random(), 4'hf, 0, RESP_SLVERR);
      read_reg(p, 9'h00c, 0, '0, RESP_SLVERR);
      read_reg(p, 9'h1fc, 0, '0, RESP_SLVERR);
      read_reg(p, REG_GEN_CONFIG, 0, cfg_model[p], RESP_OKAY);
    end
    check_config();
    report_test("error responses");

    for (int p = 0; p < NUM_PATHS; p++) begin
      wr_data = next_random();
      write_reg(p, REG_GEN_CONFIG, wr_data, 4'hf, 1 + next_random() % 8, RESP_OKAY);
      cfg_model[p] = wr_data;
      read_reg(p, REG_GEN_CONFIG, 1 + next_random() % 8, wr_data, RESP_OKAY);
      read_reg(p, 9'h020, 1 + next_random() % 8, '0, RESP_SLVERR);
    end
    check_config();
    report_test("ready stalls");

    // Sources carry opposite flags, so the sync bit shows the source path 0 picks
    for (int k = 0; k < 2; k++) begin
      rnd           = next_random();
      xphy_status   = rnd[NUM_PATHS*XPHY_STATUS_W-1:0];
      ntp_sync_ok_a = (k == 0);
      ntp_sync_ok_b = (k != 0);
      step_cycle();
      step_cycle();
      for (int p = 0; p < NUM_PATHS; p++) begin
        status_exp                     = '0;
        status_exp[STATUS_SYNC_BIT]    = cfg_model[0][CLOCK_SELECT_BIT] ? ntp_sync_ok_b
                                                                        : ntp_sync_ok_a;
        status_exp[XPHY_STATUS_W-1:0]  = xphy_status[p*XPHY_STATUS_W +: XPHY_STATUS_W];
        read_reg(p, REG_STATUS, 0, status_exp, RESP_OKAY);
      end
    end
    report_test("status word");

    for (int s = 0; s < 2; s++) begin
      write_reg(0, REG_GEN_CONFIG, {7'd0, s[0], 24'd0}, 4'b1000, 0, RESP_OKAY);
      cfg_model[0] = merge_bytes(cfg_model[0], {7'd0, s[0], 24'd0}, 4'b1000);
      check_config();
      ntp_time_a    = {next_random(), next_random()};
      ntp_time_b    = {next_random(), next_random()};
      ntp_sync_ok_a = (s == 0);
      ntp_sync_ok_b = (s == 1);
      // Unchosen strobe first, time must hold
      pulse_update(s == 0);
      check_equal("ntp_time after unchosen update", ntp_time, time_exp);
      pulse_update(s == 1);
      time_exp = (s == 1) ? ntp_time_b : ntp_time_a;
      check_equal("ntp_time after chosen update", ntp_time, time_exp);
      check_equal("ntp_sync_ok", ntp_sync_ok, 1'b1);
    end
    report_test("clock select");

    $display("tests %0d, failed tests %0d, check errors %0d, assertion failures %0d",
             NUM_TESTS, tests_failed, errors, dut_i.ntps_asserts_i.fail_count);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
ntps_pkg.sv
network_path_regs.sv
ntp_clock_select.sv
ntps_interfaces.sv
ntps_asserts.sv
tb_clock_gen.sv
tb_ntps.sv
